// File: project.f
common/bdBridgePkg.sv
verilog/wordFifo.sv
bridge/channelToBd.sv
bridge/bdToChannel.sv
verilog/bdBridgeTop.sv
dv/bdBridgeProperties_properties.sv
dv/bdBridgeTb.sv

// File: Bender.yml
package:
  name: bd_bridge

sources:
  # Shared package first, then the RTL bottom up
  - common/bdBridgePkg.sv
  - verilog/wordFifo.sv
  - bridge/channelToBd.sv
  - bridge/bdToChannel.sv
  - verilog/bdBridgeTop.sv

  # Verification sources
  - target: test
    files:
      - dv/bdBridgeProperties_properties.sv
      - dv/bdBridgeTb.sv

// File: dv/bdBridgeTb.sv
`timescale 1ns/100ps
`default_nettype none

// Testbench for the FPGA to BD bridge, both directions driven at once
module bdBridgeTb
    import bdBridgePkg::*;
;

    localparam int numRows       = 16;
    localparam int timeoutCycles = 200;

    // One row drives one word in each direction
    typedef struct packed {
        pin2coreWord_t p2c;
        core2pinWord_t c2p;
        logic [7:0]    readyDelay;
        logic [7:0]    ackDelay;
    } stimRow_t;

    logic          clk = 1'b0;
    logic          rstN;
    logic          inChanValid;
    pin2coreWord_t inChanData;
    logic          inChanAck;
    logic          bdInValid;
    pin2coreWord_t bdInData;
    logic          bdInReady;
    logic          bdOutValidN;
    core2pinWord_t bdOutData;
    logic          bdOutReady;
    logic          outChanValid;
    core2pinWord_t outChanData;
    logic          outChanAck;

    stimRow_t      rows [numRows];
    pin2coreWord_t p2cExp [$];
    core2pinWord_t c2pExp [$];
    int            errors = 0;
    bit            stalled = 1'b0;

    // Occupancy bookkeeping for the back-pressure checks
    int p2cAcked = 0;
    int p2cTaken = 0;
    int p2cHeld;
    int p2cMaxHeld = 0;
    int c2pAccepted = 0;
    int c2pAcked = 0;
    int c2pHeld;
    int c2pMaxHeld = 0;
    logic prevInAck = 1'b0;
    logic prevOutAck = 1'b0;

    always
    begin
        #4;
        clk = ~clk;
    end

    bdBridgeTop dut0 (.*);

    task automatic nextCycle();
        @(posedge clk);
        #1;
    endtask

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        assert (actual === expected)
        else
        begin
            $display("CHECK FAILED: %s expected %h got %h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic reportStall(input string what);
        $display("Timeout: the %s handshake stalled", what);
        errors++;
        stalled = 1'b1;
    endtask

    task automatic setRow(input int idx, input pin2coreWord_t p2c, input core2pinWord_t c2p,
                          input int readyDelay, input int ackDelay);
        rows[idx].p2c        = p2c;
        rows[idx].c2p        = c2p;
        rows[idx].readyDelay = 8'(readyDelay);
        rows[idx].ackDelay   = 8'(ackDelay);
    endtask

    // FPGA side sender, active four-phase
    task automatic sendChannelWord(input pin2coreWord_t word);
        int waited;
        waited      = 0;
        inChanData  = word;
        inChanValid = 1'b1;
        p2cExp.push_back(word);
        while (!inChanAck && waited < timeoutCycles)
        begin
            nextCycle();
            waited++;
        end
        if (!inChanAck)
        begin
            reportStall("pin-to-core channel ack");
        end
        else
        begin
            inChanValid = 1'b0;
            waited      = 0;
            while (inChanAck && waited < timeoutCycles)
            begin
                nextCycle();
                waited++;
            end
            if (inChanAck)
            begin
                reportStall("pin-to-core channel ack release");
            end
        end
    endtask

    // BD sink, raises ready after the row delay and takes one word
    task automatic takeBdWord(input int readyDelay);
        pin2coreWord_t expWord;
        int            waited;
        waited = 0;
        repeat (readyDelay) nextCycle();
        bdInReady = 1'b1;
        // Sampled mid-cycle, the transfer happens at the next rising edge
        @(negedge clk);
        while (!bdInValid && waited < timeoutCycles)
        begin
            @(negedge clk);
            waited++;
        end
        if (!bdInValid)
        begin
            reportStall("pin-to-core BD ready/valid");
        end
        else
        begin
            assert (p2cExp.size() > 0)
            begin
                expWord = p2cExp.pop_front();
                checkValue("bdInData", bdInData, expWord);
            end
            else
            begin
                $display("The BD received a pin-to-core word that was never sent");
                errors++;
            end
        end
        nextCycle();
        bdInReady = 1'b0;
    endtask

    // BD source with active-low valid
    task automatic sendBdWord(input core2pinWord_t word);
        int waited;
        waited      = 0;
        bdOutData   = word;
        bdOutValidN = 1'b0;
        c2pExp.push_back(word);
        @(negedge clk);
        while (!bdOutReady && waited < timeoutCycles)
        begin
            @(negedge clk);
            waited++;
        end
        if (!bdOutReady)
        begin
            reportStall("core-to-pin BD ready/valid");
        end
        nextCycle();
        bdOutValidN = 1'b1;
    endtask

    // FPGA side receiver, passive four-phase with a delayed ack
    task automatic ackChannelWord(input int ackDelay);
        core2pinWord_t expWord;
        int            waited;
        waited = 0;
        while (!outChanValid && waited < timeoutCycles)
        begin
            nextCycle();
            waited++;
        end
        if (!outChanValid)
        begin
            reportStall("core-to-pin channel valid");
        end
        else
        begin
            assert (c2pExp.size() > 0)
            begin
                expWord = c2pExp.pop_front();
                checkValue("outChanData", outChanData, expWord);
            end
            else
            begin
                $display("The FPGA received a core-to-pin word that was never sent");
                errors++;
            end
            repeat (ackDelay) nextCycle();
            outChanAck = 1'b1;
            waited     = 0;
            while (outChanValid && waited < timeoutCycles)
            begin
                nextCycle();
                waited++;
            end
            if (outChanValid)
            begin
                reportStall("core-to-pin channel valid release");
            end
            outChanAck = 1'b0;
        end
    endtask

    // Words held inside the bridge, sampled mid-cycle
    always @(negedge clk)
    begin
        if (rstN)
        begin
            // An ack rise marks a word stored at the previous edge
            if (inChanAck && !prevInAck)
            begin
                p2cAcked++;
            end
            p2cHeld = p2cAcked - p2cTaken;
            assert (p2cHeld <= fifoDepth)
            else
            begin
                $display("CHECK FAILED: p2cHeld expected <= %h got %h", fifoDepth, p2cHeld);
                errors++;
            end
            if (p2cHeld > p2cMaxHeld)
            begin
                p2cMaxHeld = p2cHeld;
            end
            if (bdInValid && bdInReady)
            begin
                p2cTaken++;
            end

            if (outChanAck && !prevOutAck)
            begin
                c2pAcked++;
            end
            c2pHeld = c2pAccepted - c2pAcked;
            // FIFO full plus the word on the channel
            if (c2pHeld == fifoDepth + 1)
            begin
                checkValue("bdOutReady", bdOutReady, 0);
            end
            if (!bdOutValidN && bdOutReady)
            begin
                c2pAccepted++;
            end
            c2pHeld = c2pAccepted - c2pAcked;
            if (c2pHeld > c2pMaxHeld)
            begin
                c2pMaxHeld = c2pHeld;
            end
        end
        prevInAck  = inChanAck;
        prevOutAck = outChanAck;
    end

    initial
    begin
        rstN        = 1'b0;
        inChanValid = 1'b0;
        inChanData  = '0;
        bdInReady   = 1'b0;
        bdOutValidN = 1'b1;
        bdOutData   = '0;
        outChanAck  = 1'b0;
        void'($urandom(62399));

        // Slow BD first, then a slow FPGA, then random traffic
        setRow(0, {5'h01, 16'h1111}, {4'h1, 16'ha001}, 20, 0);
        setRow(1, {5'h02, 16'h2222}, {4'h2, 16'ha002}, 20, 0);
        setRow(2, {5'h03, 16'h3333}, {4'h3, 16'ha003}, 20, 0);
        setRow(3, {5'h1f, 16'hffff}, {4'hf, 16'hffff}, 20, 0);
        setRow(4, {5'h00, 16'h0000}, {4'h0, 16'h0000}, 0, 20);
        setRow(5, {5'h15, 16'h5555}, {4'h5, 16'h5555}, 0, 20);
        setRow(6, {5'h0a, 16'haaaa}, {4'ha, 16'haaaa}, 0, 20);
        setRow(7, {5'h10, 16'h8001}, {4'h8, 16'h0001}, 0, 20);
        for (int i = 8; i < numRows; i++)
        begin
            setRow(i, pin2coreWidth'($urandom), core2pinWidth'($urandom),
                   $urandom % 6, $urandom % 6);
        end

        repeat (10) @(posedge clk);
        #1;
        rstN = 1'b1;

        checkValue("inChanAck", inChanAck, 0);
        checkValue("bdInValid", bdInValid, 0);
        checkValue("outChanValid", outChanValid, 0);
        checkValue("bdOutReady", bdOutReady, 1);

        fork
            for (int i = 0; i < numRows && !stalled; i++) sendChannelWord(rows[i].p2c);
            for (int i = 0; i < numRows && !stalled; i++) takeBdWord(rows[i].readyDelay);
            for (int i = 0; i < numRows && !stalled; i++) sendBdWord(rows[i].c2p);
            for (int i = 0; i < numRows && !stalled; i++) ackChannelWord(rows[i].ackDelay);
        join

        // Nothing left over in either direction
        repeat (4) nextCycle();
        checkValue("bdInValid", bdInValid, 0);
        checkValue("outChanValid", outChanValid, 0);
        checkValue("p2cExp.size", p2cExp.size(), 0);
        checkValue("c2pExp.size", c2pExp.size(), 0);
        checkValue("p2cMaxHeld", p2cMaxHeld, fifoDepth);
        checkValue("c2pMaxHeld", c2pMaxHeld, fifoDepth + 1);

        $display("Testbench errors: %0d, assertion failures: %0d",
                 errors, dut0.props0.failCount);
        if (errors == 0 && dut0.props0.failCount == 0)
        begin
            $display("NO ERRORS");
        end
        else
        begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: dv/bdBridgeProperties_properties.sv
`timescale 1ns/100ps
`default_nettype none

// Handshake rules on the bridge ports
module bdBridgeProperties
    import bdBridgePkg::*;
(
    input logic          clk,
    input logic          rstN,
    input logic          inChanValid,
    input pin2coreWord_t inChanData,
    input logic          inChanAck,
    input logic          bdInValid,
    input pin2coreWord_t bdInData,
    input logic          bdInReady,
    input logic          bdOutValidN,
    input core2pinWord_t bdOutData,
    input logic          bdOutReady,
    input logic          outChanValid,
    input core2pinWord_t outChanData,
    input logic          outChanAck
);

    int failCount = 0;

    // Data holds while a valid waits for its ack or ready
    inChanStable: assert property (@(posedge clk) disable iff (!rstN)
        (inChanValid && !inChanAck) |=> (!inChanValid || $stable(inChanData)))
    else
    begin
        $error("inChanData changed while waiting for ack");
        failCount++;
    end

    bdInStable: assert property (@(posedge clk) disable iff (!rstN)
        (bdInValid && !bdInReady) |=> (bdInValid && $stable(bdInData)))
    else
    begin
        $error("bdInData or bdInValid changed before transfer");
        failCount++;
    end

    bdOutStable: assert property (@(posedge clk) disable iff (!rstN)
        (!bdOutValidN && !bdOutReady) |=> (!bdOutValidN && $stable(bdOutData)))
    else
    begin
        $error("bdOutData or bdOutValidN changed before transfer");
        failCount++;
    end

    outChanStable: assert property (@(posedge clk) disable iff (!rstN)
        (outChanValid && !outChanAck) |=> (outChanValid && $stable(outChanData)))
    else
    begin
        $error("outChanData or outChanValid changed before ack");
        failCount++;
    end

    // Four-phase ordering on both channels, judged at the edge that made the change
    inAckRise: assert property (@(posedge clk) disable iff (!rstN)
        $rose(inChanAck) |-> $past(inChanValid))
    else
    begin
        $error("inChanAck rose without inChanValid");
        failCount++;
    end

    outValidRise: assert property (@(posedge clk) disable iff (!rstN)
        $rose(outChanValid) |-> $past(!outChanAck))
    else
    begin
        $error("outChanValid rose while outChanAck was high");
        failCount++;
    end

endmodule

bind bdBridgeTop bdBridgeProperties props0 (.*);

`default_nettype wire

// File: verilog/bdBridgeTop.sv
`timescale 1ns/100ps
`default_nettype none

// FPGA to BD bridge, both directions on one clock
module bdBridgeTop
    import bdBridgePkg::*;
(
    input  logic          clk,
    input  logic          rstN,

    // Pin-to-core channel from the FPGA
    input  logic          inChanValid,
    input  pin2coreWord_t inChanData,
    output logic          inChanAck,

    // Pin-to-core BD pins
    output logic          bdInValid,
    output pin2coreWord_t bdInData,
    input  logic          bdInReady,

    // Core-to-pin BD pins
    input  logic          bdOutValidN,
    input  core2pinWord_t bdOutData,
    output logic          bdOutReady,

    // Core-to-pin channel to the FPGA
    output logic          outChanValid,
    output core2pinWord_t outChanData,
    input  logic          outChanAck
);

    // Pin-to-core direction
    channelToBd chanToBd0 (
        .clk       (clk),
        .rstN      (rstN),
        .chanValid (inChanValid),
        .chanData  (inChanData),
        .chanAck   (inChanAck),
        .bdValid   (bdInValid),
        .bdData    (bdInData),
        .bdReady   (bdInReady)
    );

    // Core-to-pin direction
    bdToChannel bdToChan0 (
        .clk       (clk),
        .rstN      (rstN),
        .bdValidN  (bdOutValidN),
        .bdData    (bdOutData),
        .bdReady   (bdOutReady),
        .chanValid (outChanValid),
        .chanData  (outChanData),
        .chanAck   (outChanAck)
    );

endmodule

`default_nettype wire

// File: bridge/bdToChannel.sv
`timescale 1ns/100ps
`default_nettype none

// Ready/valid receiver from the BD, active four-phase sender
// toward the FPGA channel
module bdToChannel
    import bdBridgePkg::*;
(
    input  logic          clk,
    input  logic          rstN,

    // BD pins, valid is active low
    input  logic          bdValidN,
    input  core2pinWord_t bdData,
    output logic          bdReady,

    // FPGA channel, four-phase
    output logic          chanValid,
    output core2pinWord_t chanData,
    input  logic          chanAck
);

    typedef enum logic [1:0] {
        sendIdle,
        sendWaitAck,
        sendWaitRelease
    } sendState_t;

    sendState_t    state;
    logic          bdValid;
    logic          fifoPush;
    logic          fifoPop;
    logic          fifoFull;
    logic          fifoEmpty;
    core2pinWord_t fifoHead;
    logic          chanValidReg;
    core2pinWord_t chanDataReg;

    assign bdValid  = !bdValidN;
    assign bdReady  = !fifoFull;
    assign fifoPush = bdValid && bdReady;

    // Head leaves the FIFO as it is loaded into the output register
    assign fifoPop = (state == sendIdle) && !fifoEmpty;

    wordFifo #(
        .payload_t (core2pinWord_t)
    ) fifo0 (
        .clk      (clk),
        .rstN     (rstN),
        .push     (fifoPush),
        .pushData (bdData),
        .pop      (fifoPop),
        .popData  (fifoHead),
        .full     (fifoFull),
        .empty    (fifoEmpty)
    );

    // Output word register
    always_ff @(posedge clk)
    begin
        if (fifoPop)
        begin
            chanDataReg <= fifoHead;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rstN)
        begin
            state        <= sendIdle;
            chanValidReg <= 1'b0;
        end
        else
        begin
            case (state)
                sendIdle:
                begin
                    if (!fifoEmpty)
                    begin
                        chanValidReg <= 1'b1;
                        state        <= sendWaitAck;
                    end
                end
                sendWaitAck:
                begin
                    if (chanAck)
                    begin
                        chanValidReg <= 1'b0;
                        state        <= sendWaitRelease;
                    end
                end
                sendWaitRelease:
                begin
                    // Receiver must drop ack before the next word
                    if (!chanAck)
                    begin
                        state <= sendIdle;
                    end
                end
                default:
                begin
                    state        <= sendIdle;
                    chanValidReg <= 1'b0;
                end
            endcase
        end
    end

    assign chanValid = chanValidReg;
    assign chanData  = chanDataReg;

endmodule

`default_nettype wire

// File: bridge/channelToBd.sv
`timescale 1ns/100ps
`default_nettype none

// Passive four-phase receiver on the FPGA side,
// ready/valid source toward the BD
module channelToBd
    import bdBridgePkg::*;
(
    input  logic          clk,
    input  logic          rstN,

    // FPGA channel, four-phase
    input  logic          chanValid,
    input  pin2coreWord_t chanData,
    output logic          chanAck,

    // BD pins, ready/valid
    output logic          bdValid,
    output pin2coreWord_t bdData,
    input  logic          bdReady
);

    logic          ackReg;
    logic          fifoPush;
    logic          fifoPop;
    logic          fifoFull;
    logic          fifoEmpty;
    pin2coreWord_t fifoHead;

    // Store once per valid phase, only while ack is still low
    assign fifoPush = chanValid && !ackReg && !fifoFull;

    // Transfer to the BD on valid and ready
    assign fifoPop = bdValid && bdReady;

    always_ff @(posedge clk)
    begin
        if (!rstN)
        begin
            ackReg <= 1'b0;
        end
        else if (fifoPush)
        begin
            // Word stored this edge, acknowledge it
            ackReg <= 1'b1;
        end
        else if (ackReg && !chanValid)
        begin
            // Sender has let go of valid, close the phase
            ackReg <= 1'b0;
        end
    end

    assign chanAck = ackReg;

    wordFifo #(
        .payload_t (pin2coreWord_t)
    ) fifo0 (
        .clk      (clk),
        .rstN     (rstN),
        .push     (fifoPush),
        .pushData (chanData),
        .pop      (fifoPop),
        .popData  (fifoHead),
        .full     (fifoFull),
        .empty    (fifoEmpty)
    );

    // FIFO head is the BD side source, held until taken
    assign bdValid = !fifoEmpty;
    assign bdData  = fifoHead;

endmodule

`default_nettype wire

// File: verilog/wordFifo.sv
`timescale 1ns/100ps
`default_nettype none

// Small circular buffer, payload type set per instance
module wordFifo
    import bdBridgePkg::*;
#(
    parameter type payload_t = logic [7:0]
)
(
    input  logic     clk,
    input  logic     rstN,
    input  logic     push,
    input  payload_t pushData,
    input  logic     pop,
    output payload_t popData,
    output logic     full,
    output logic     empty
);

    payload_t                  mem [fifoDepth];
    logic [fifoPtrWidth-1:0]   wrPtr;
    logic [fifoPtrWidth-1:0]   rdPtr;
    logic [fifoCountWidth-1:0] count;
    logic                      pushOk;
    logic                      popOk;

    // Pointer increment with wrap at the last entry
    function automatic logic [fifoPtrWidth-1:0] nextPtr(input logic [fifoPtrWidth-1:0] ptr);
        if (ptr == fifoPtrWidth'(fifoDepth - 1))
        begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign full   = (count == fifoCountWidth'(fifoDepth));
    assign empty  = (count == '0);

    // Requests against a full or empty buffer are dropped here
    assign pushOk = push && !full;
    assign popOk  = pop && !empty;

    // Head entry, valid whenever not empty
    assign popData = mem[rdPtr];

    always_ff @(posedge clk)
    begin
        if (pushOk)
        begin
            mem[wrPtr] <= pushData;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rstN)
        begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end
        else
        begin
            if (pushOk)
            begin
                wrPtr <= nextPtr(wrPtr);
            end
            if (popOk)
            begin
                rdPtr <= nextPtr(rdPtr);
            end
            // Simultaneous push and pop leaves occupancy unchanged
            case ({pushOk, popOk})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: common/bdBridgePkg.sv
`default_nettype none

// Shared widths, FIFO sizing and word layouts for the FPGA to BD bridge
package bdBridgePkg;

    // Word widths on the BD pins
    localparam int pin2coreWidth = 21;
    localparam int core2pinWidth = 20;

    // Both word types carry the same payload field
    localparam int payloadWidth = 16;
    localparam int destWidth    = pin2coreWidth - payloadWidth;
    localparam int tagWidth     = core2pinWidth - payloadWidth;

    // Entries in each direction's FIFO
    localparam int fifoDepth = 2;

    // Pointer and occupancy widths derived from the depth
    localparam int fifoPtrWidth   = $clog2(fifoDepth);
    localparam int fifoCountWidth = $clog2(fifoDepth + 1);

    // FPGA channel to BD
    typedef struct packed {
        logic [destWidth-1:0]    dest;
        logic [payloadWidth-1:0] payload;
    } pin2coreWord_t;

    // BD to FPGA channel
    typedef struct packed {
        logic [tagWidth-1:0]     tag;
        logic [payloadWidth-1:0] payload;
    } core2pinWord_t;

endpackage

`default_nettype wire
